// ==== bench/tb_lane.sv ====
/*
 Testbench of the reduced vector lane.
 Keeps its own VRF model, filled by its loads and updated by the ALU
 rules, with SUB as vs2 - vs1 modulo 2^32. Concurrent assertions check
 the store stream and the handshake timing against that model.
 Loads are only issued while the lane is idle.
*/

`timescale 1ns/1ps

`include "lane_settings.svh"

module tb_lane import lane_pkg::*; ();

  localparam int unsigned NR_WORDS = `LANE_NR_VREGS * `LANE_ELEMS_PER_VREG;
  localparam int unsigned TIMEOUT  = 1000;
  localparam logic [31:0] SEED     = 32'hbcd6329f;

  logic        clk;
  logic        rst_n;
  logic        pe_req_valid;
  lane_op_e    pe_op;
  vreg_t       pe_vd;
  vreg_t       pe_vs1;
  vreg_t       pe_vs2;
  vlen_t       pe_vl;
  logic        pe_req_ready;
  logic        pe_vinsn_done;
  logic        ldu_req;
  vaddr_t      ldu_addr;
  elem_t       ldu_wdata;
  strb_t       ldu_be;
  logic        ldu_gnt;
  elem_t       stu_data;
  logic        stu_valid;
  logic        stu_ready  = 1'b1;
  logic        bp_en      = 1'b0;
  logic [31:0] rand_state = SEED;
  logic [31:0] bp_state   = ~SEED;
  elem_t       model [NR_WORDS];
  string       test_name;
  int          insn_cnt;

  lane i_dut (
    .clk_i              (clk          ),
    .rst_ni             (rst_n        ),
    .pe_req_valid_i     (pe_req_valid ),
    .pe_op_i            (pe_op        ),
    .pe_vd_i            (pe_vd        ),
    .pe_vs1_i           (pe_vs1       ),
    .pe_vs2_i           (pe_vs2       ),
    .pe_vl_i            (pe_vl        ),
    .pe_req_ready_o     (pe_req_ready ),
    .pe_vinsn_done_o    (pe_vinsn_done),
    .ldu_req_i          (ldu_req      ),
    .ldu_addr_i         (ldu_addr     ),
    .ldu_wdata_i        (ldu_wdata    ),
    .ldu_be_i           (ldu_be       ),
    .ldu_gnt_o          (ldu_gnt      ),
    .stu_operand_o      (stu_data     ),
    .stu_operand_valid_o(stu_valid    ),
    .stu_operand_ready_i(stu_ready    )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rand_state = xorshift32(rand_state);
    return rand_state;
  endfunction

  // Element result, vs1 and vs2 as in the instruction
  function automatic elem_t expected_result(input lane_op_e op, input elem_t vs1_val,
                                            input elem_t vs2_val);
    case (op)
      OP_ADD:  return vs2_val + vs1_val;
      OP_SUB:  return vs2_val - vs1_val;
      OP_AND:  return vs2_val & vs1_val;
      OP_OR:   return vs2_val | vs1_val;
      default: return vs2_val ^ vs1_val;
    endcase
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    abort_run($sformatf("Mismatch in %s (%s): expected %h, actual %h",
                        test_name, what, exp, act));
  endtask

  // Random store port back-pressure, own generator state
  always @(negedge clk) begin
    bp_state  = xorshift32(bp_state);
    stu_ready = bp_en ? bp_state[7] : 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor and checks
  //////////////////////////////////////////////////////////////////////

  logic  in_flight;
  logic  started;
  logic  cur_is_store;
  vlen_t cur_vl;
  vreg_t cur_vs2;
  vlen_t hs_cnt;
  int    done_cnt;
  logic  stu_hs;
  elem_t exp_store;

  assign stu_hs    = stu_valid && stu_ready;
  assign exp_store = model[{cur_vs2, velem_t'(hs_cnt)}];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight    <= 1'b0;
      started      <= 1'b0;
      cur_is_store <= 1'b0;
      cur_vl       <= '0;
      cur_vs2      <= '0;
      hs_cnt       <= '0;
      done_cnt     <= 0;
    end else begin
      if (pe_req_valid && pe_req_ready) begin
        in_flight    <= 1'b1;
        started      <= 1'b1;
        cur_is_store <= (pe_op == OP_STORE);
        cur_vl       <= pe_vl;
        cur_vs2      <= pe_vs2;
        hs_cnt       <= '0;
      end else if (pe_vinsn_done) begin
        in_flight <= 1'b0;
        done_cnt  <= done_cnt + 1;
      end
      if (stu_hs) begin
        hs_cnt <= hs_cnt + vlen_t'(1);
      end
    end
  end

  a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> pe_req_ready && !stu_valid && !pe_vinsn_done)
    else abort_run("Lane outputs left their idle values before the first instruction");

  // No writeback competes while the lane is idle
  a_load_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !in_flight |-> ldu_gnt == ldu_req)
    else abort_run("Load grant does not follow the load request on an idle lane");

  a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
    stu_hs |-> stu_data == exp_store)
    else report_mismatch("store element", $sampled(exp_store), $sampled(stu_data));

  a_store_owner: assert property (@(posedge clk) disable iff (!rst_n)
    stu_hs |-> in_flight && cur_is_store && (hs_cnt < cur_vl))
    else abort_run("Store port handshake outside the elements of a running store");

  a_store_done: assert property (@(posedge clk) disable iff (!rst_n)
    stu_hs && (hs_cnt + vlen_t'(1) == cur_vl) |=> pe_vinsn_done)
    else abort_run("No done pulse in the cycle after the last store handshake");

  a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
    pe_vinsn_done && cur_is_store |-> hs_cnt == cur_vl)
    else report_mismatch("store handshakes at done", 32'($sampled(cur_vl)),
                         32'($sampled(hs_cnt)));

  a_done_owner: assert property (@(posedge clk) disable iff (!rst_n)
    pe_vinsn_done |-> in_flight)
    else abort_run("Done pulse without an instruction in flight");

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight |-> !pe_req_ready)
    else abort_run("Request ready high while an instruction is in flight");

  a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
    pe_vinsn_done |=> pe_req_ready)
    else abort_run("Request ready did not return the cycle after done");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic load_word(input vaddr_t addr, input elem_t data, input strb_t be);
    int waited;
    int b;
    @(negedge clk);
    ldu_req   = 1'b1;
    ldu_addr  = addr;
    ldu_wdata = data;
    ldu_be    = be;
    waited    = 0;
    #1;
    while (!ldu_gnt) begin
      if (waited == TIMEOUT) abort_run("Load request not granted before timeout");
      waited++;
      @(negedge clk);
      #1;
    end
    // Written at the coming rising edge
    for (b = 0; b < $bits(strb_t); b++) begin
      if (be[b]) model[addr][8*b +: 8] = data[8*b +: 8];
    end
    @(negedge clk);
    ldu_req = 1'b0;
  endtask

  task automatic run_insn(input lane_op_e op, input vreg_t vd, input vreg_t vs1,
                          input vreg_t vs2, input vlen_t vl);
    int waited;
    @(negedge clk);
    pe_req_valid = 1'b1;
    pe_op        = op;
    pe_vd        = vd;
    pe_vs1       = vs1;
    pe_vs2       = vs2;
    pe_vl        = vl;
    waited       = 0;
    while (!pe_req_ready) begin
      if (waited == TIMEOUT) abort_run("Instruction not accepted before timeout");
      waited++;
      @(negedge clk);
    end
    insn_cnt++;
    @(negedge clk);
    pe_req_valid = 1'b0;
    waited       = 0;
    while (!pe_vinsn_done) begin
      if (waited == TIMEOUT) abort_run("No done pulse before timeout");
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic store_reg(input vreg_t vs2, input vlen_t vl);
    run_insn(OP_STORE, '0, '0, vs2, vl);
  endtask

  // Random registers and length, then the whole destination is streamed out
  task automatic alu_insn(input lane_op_e op);
    logic [31:0] r;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    vlen_t       vl;
    int          i;
    r   = next_rand();
    vd  = r[2:0];
    vs1 = r[5:3];
    vs2 = r[8:6];
    vl  = vlen_t'(r[11:9]) + vlen_t'(1);
    run_insn(op, vd, vs1, vs2, vl);
    for (i = 0; i < int'(vl); i++) begin
      model[{vd, velem_t'(i)}] = expected_result(op, model[{vs1, velem_t'(i)}],
                                                 model[{vs2, velem_t'(i)}]);
    end
    store_reg(vd, vlen_t'(`LANE_ELEMS_PER_VREG));
  endtask

  initial begin
    logic [31:0] r;
    elem_t       data;
    int          i;
    test_name    = "reset";
    insn_cnt     = 0;
    pe_req_valid = 1'b0;
    pe_op        = OP_ADD;
    pe_vd        = '0;
    pe_vs1       = '0;
    pe_vs2       = '0;
    pe_vl        = '0;
    ldu_req      = 1'b0;
    ldu_addr     = '0;
    ldu_wdata    = '0;
    ldu_be       = '0;
    rst_n        = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    // Full fill first, then partial byte writes
    test_name = "load_store";
    for (i = 0; i < NR_WORDS; i++) begin
      data = next_rand();
      load_word(vaddr_t'(i), data, '1);
    end
    for (i = 0; i < 24; i++) begin
      r    = next_rand();
      data = next_rand();
      load_word(vaddr_t'(r[5:0]), data, strb_t'(r[11:8]));
    end
    for (i = 0; i < `LANE_NR_VREGS; i++) begin
      store_reg(vreg_t'(i), vlen_t'(`LANE_ELEMS_PER_VREG));
    end

    test_name = "arith";
    for (i = 0; i < 8; i++) begin
      r = next_rand();
      alu_insn(r[0] ? OP_SUB : OP_ADD);
    end

    test_name = "logic";
    for (i = 0; i < 9; i++) begin
      alu_insn(lane_op_e'(32'(OP_AND) + (i % 3)));
    end

    test_name = "backpressure";
    bp_en     = 1'b1;
    for (i = 0; i < 8; i++) begin
      r = next_rand();
      store_reg(vreg_t'(r[2:0]), vlen_t'(r[5:3]) + vlen_t'(1));
    end
    alu_insn(OP_XOR);
    bp_en = 1'b0;

    test_name = "summary";
    repeat (4) @(negedge clk);
    if (done_cnt == insn_cnt) begin
      $display("TEST OK");
      $finish;
    end else begin
      report_mismatch("done pulses", insn_cnt, done_cnt);
    end
  end

endmodule

// ==== design/lane.sv ====
/*
 Reduced vector lane, one lane with a single-bank VRF.
 One instruction at a time on the request port.
 Loads must not target a register used by the running instruction.
*/

`timescale 1ns/1ps

module lane import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Instruction port
  input  logic     pe_req_valid_i,
  input  lane_op_e pe_op_i,
  input  vreg_t    pe_vd_i,
  input  vreg_t    pe_vs1_i,
  input  vreg_t    pe_vs2_i,
  input  vlen_t    pe_vl_i,
  output logic     pe_req_ready_o,
  output logic     pe_vinsn_done_o,
  // Load port
  input  logic     ldu_req_i,
  input  vaddr_t   ldu_addr_i,
  input  elem_t    ldu_wdata_i,
  input  strb_t    ldu_be_i,
  output logic     ldu_gnt_o,
  // Store port
  output elem_t    stu_operand_o,
  output logic     stu_operand_valid_o,
  input  logic     stu_operand_ready_i
);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  logic     opreq_valid;
  logic     opreq_ready;
  vreg_t    opreq_vs1;
  vreg_t    opreq_vs2;
  vlen_t    opreq_vl;
  logic     opreq_to_store;
  logic     alu_cmd_valid;
  lane_op_e alu_op;
  vreg_t    alu_vd;
  vlen_t    alu_vl;
  logic     alu_done;
  logic     stu_handshake;

  assign stu_handshake = stu_operand_valid_o && stu_operand_ready_i;

  lane_sequencer i_lane_sequencer (
    .clk_i           (clk_i          ),
    .rst_ni          (rst_ni         ),
    .pe_req_valid_i  (pe_req_valid_i ),
    .pe_op_i         (pe_op_i        ),
    .pe_vd_i         (pe_vd_i        ),
    .pe_vs1_i        (pe_vs1_i       ),
    .pe_vs2_i        (pe_vs2_i       ),
    .pe_vl_i         (pe_vl_i        ),
    .pe_req_ready_o  (pe_req_ready_o ),
    .pe_vinsn_done_o (pe_vinsn_done_o),
    .opreq_valid_o   (opreq_valid    ),
    .opreq_ready_i   (opreq_ready    ),
    .opreq_vs1_o     (opreq_vs1      ),
    .opreq_vs2_o     (opreq_vs2      ),
    .opreq_vl_o      (opreq_vl       ),
    .opreq_to_store_o(opreq_to_store ),
    .alu_cmd_valid_o (alu_cmd_valid  ),
    .alu_op_o        (alu_op         ),
    .alu_vd_o        (alu_vd         ),
    .alu_vl_o        (alu_vl         ),
    .alu_done_i      (alu_done       ),
    .stu_handshake_i (stu_handshake  )
  );

  //////////////////////////////////////////////////////////////////////
  // VRF access
  //////////////////////////////////////////////////////////////////////

  logic       alu_wb_req;
  vaddr_t     alu_wb_addr;
  elem_t      alu_wb_data;
  logic       alu_wb_gnt;
  logic       vrf_req;
  logic       vrf_we;
  vaddr_t     vrf_addr;
  elem_t      vrf_wdata;
  strb_t      vrf_be;
  elem_t      vrf_rdata;
  logic [2:0] q_almost_free;
  logic [2:0] q_push;
  elem_t      q_data;

  operand_requester i_operand_requester (
    .clk_i           (clk_i         ),
    .rst_ni          (rst_ni        ),
    .opreq_valid_i   (opreq_valid   ),
    .opreq_ready_o   (opreq_ready   ),
    .opreq_vs1_i     (opreq_vs1     ),
    .opreq_vs2_i     (opreq_vs2     ),
    .opreq_vl_i      (opreq_vl      ),
    .opreq_to_store_i(opreq_to_store),
    .ldu_req_i       (ldu_req_i     ),
    .ldu_addr_i      (ldu_addr_i    ),
    .ldu_wdata_i     (ldu_wdata_i   ),
    .ldu_be_i        (ldu_be_i      ),
    .ldu_gnt_o       (ldu_gnt_o     ),
    .alu_wb_req_i    (alu_wb_req    ),
    .alu_wb_addr_i   (alu_wb_addr   ),
    .alu_wb_data_i   (alu_wb_data   ),
    .alu_wb_gnt_o    (alu_wb_gnt    ),
    .vrf_req_o       (vrf_req       ),
    .vrf_we_o        (vrf_we        ),
    .vrf_addr_o      (vrf_addr      ),
    .vrf_wdata_o     (vrf_wdata     ),
    .vrf_be_o        (vrf_be        ),
    .vrf_rdata_i     (vrf_rdata     ),
    .q_almost_free_i (q_almost_free ),
    .q_push_o        (q_push        ),
    .q_data_o        (q_data        )
  );

  vector_regfile i_vrf (
    .clk_i  (clk_i    ),
    .rst_ni (rst_ni   ),
    .req_i  (vrf_req  ),
    .we_i   (vrf_we   ),
    .addr_i (vrf_addr ),
    .wdata_i(vrf_wdata),
    .be_i   (vrf_be   ),
    .rdata_o(vrf_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Operand queues and ALU
  //////////////////////////////////////////////////////////////////////

  elem_t alu_a;
  elem_t alu_b;
  logic  alu_a_valid;
  logic  alu_b_valid;
  logic  alu_a_ready;
  logic  alu_b_ready;

  operand_queue i_vs1_queue (
    .clk_i        (clk_i           ),
    .rst_ni       (rst_ni          ),
    .push_i       (q_push[0]       ),
    .data_i       (q_data          ),
    .almost_free_o(q_almost_free[0]),
    .data_o       (alu_a           ),
    .valid_o      (alu_a_valid     ),
    .ready_i      (alu_a_ready     )
  );

  operand_queue i_vs2_queue (
    .clk_i        (clk_i           ),
    .rst_ni       (rst_ni          ),
    .push_i       (q_push[1]       ),
    .data_i       (q_data          ),
    .almost_free_o(q_almost_free[1]),
    .data_o       (alu_b           ),
    .valid_o      (alu_b_valid     ),
    .ready_i      (alu_b_ready     )
  );

  // Drives the store port directly
  operand_queue i_store_queue (
    .clk_i        (clk_i              ),
    .rst_ni       (rst_ni             ),
    .push_i       (q_push[2]          ),
    .data_i       (q_data             ),
    .almost_free_o(q_almost_free[2]   ),
    .data_o       (stu_operand_o      ),
    .valid_o      (stu_operand_valid_o),
    .ready_i      (stu_operand_ready_i)
  );

  lane_alu i_lane_alu (
    .clk_i      (clk_i        ),
    .rst_ni     (rst_ni       ),
    .cmd_valid_i(alu_cmd_valid),
    .op_i       (alu_op       ),
    .vd_i       (alu_vd       ),
    .vl_i       (alu_vl       ),
    .a_i        (alu_a        ),
    .a_valid_i  (alu_a_valid  ),
    .a_ready_o  (alu_a_ready  ),
    .b_i        (alu_b        ),
    .b_valid_i  (alu_b_valid  ),
    .b_ready_o  (alu_b_ready  ),
    .wb_req_o   (alu_wb_req   ),
    .wb_addr_o  (alu_wb_addr  ),
    .wb_data_o  (alu_wb_data  ),
    .wb_gnt_i   (alu_wb_gnt   ),
    .done_o     (alu_done     )
  );

endmodule

// ==== design/lane_alu.sv ====
/*
 Element-wise integer ALU of the lane.
 Pops a vs1/vs2 pair when both are valid, then holds the writeback
 request until granted. SUB computes vs2 - vs1, wrapping modulo 2^32.
 A new command is only given while the ALU is idle.
*/

`timescale 1ns/1ps

module lane_alu import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Command from the sequencer
  input  logic     cmd_valid_i,
  input  lane_op_e op_i,
  input  vreg_t    vd_i,
  input  vlen_t    vl_i,
  // Operands, a from vs1 and b from vs2
  input  elem_t    a_i,
  input  logic     a_valid_i,
  output logic     a_ready_o,
  input  elem_t    b_i,
  input  logic     b_valid_i,
  output logic     b_ready_o,
  // Writeback
  output logic     wb_req_o,
  output vaddr_t   wb_addr_o,
  output elem_t    wb_data_o,
  input  logic     wb_gnt_i,
  output logic     done_o
);

  logic     busy_q;
  logic     pend_q;
  logic     done_q;
  lane_op_e op_q;
  vreg_t    vd_q;
  vlen_t    vl_q;
  velem_t   idx_q;
  elem_t    res_q;
  elem_t    res_d;
  logic     pop;

  // A pair may enter as the pending result leaves
  assign pop       = busy_q && (!pend_q || wb_gnt_i) && a_valid_i && b_valid_i;
  assign a_ready_o = pop;
  assign b_ready_o = pop;

  always_comb begin
    unique case (op_q)
      OP_ADD:  res_d = b_i + a_i;
      OP_SUB:  res_d = b_i - a_i;
      OP_AND:  res_d = b_i & a_i;
      OP_OR:   res_d = b_i | a_i;
      OP_XOR:  res_d = b_i ^ a_i;
      default: res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (cmd_valid_i) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end else if (pend_q && wb_gnt_i) begin
        idx_q <= idx_q + 1'b1;
        if (vlen_t'(idx_q) + vlen_t'(1) == vl_q) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
      if (pop) begin
        pend_q <= 1'b1;
      end else if (wb_gnt_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      op_q <= op_i;
      vd_q <= vd_i;
      vl_q <= vl_i;
    end
    if (pop) begin
      res_q <= res_d;
    end
  end

  assign wb_req_o  = pend_q;
  assign wb_addr_o = {vd_q, idx_q};
  assign wb_data_o = res_q;
  assign done_o    = done_q;

  // No operand pair arrives beyond the vl elements of the command
  a_wb_in_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_req_o |-> busy_q);

endmodule

// ==== design/lane_pkg.sv ====
/*
 Types shared by the lane modules.
 All widths follow lane_settings.svh, so the header must be on the
 include path when this package is compiled.
*/

`include "lane_settings.svh"

package lane_pkg;

  // One element and its byte enables
  typedef logic [`LANE_ELEM_W-1:0] elem_t;
  typedef logic [`LANE_ELEM_W/8-1:0] strb_t;

  // Register and element indices
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(`LANE_ELEMS_PER_VREG)-1:0] velem_t;

  // VRF word address, register index above element index
  typedef logic [$clog2(`LANE_NR_VREGS*`LANE_ELEMS_PER_VREG)-1:0] vaddr_t;

  // Vector length, one bit wider than an element index to hold the full length
  typedef logic [$clog2(`LANE_ELEMS_PER_VREG):0] vlen_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_STORE
  } lane_op_e;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_DONE
  } seq_state_e;

endpackage

// ==== design/lane_sequencer.sv ====
/*
 Lane control FSM, one instruction in flight at a time.
 An ALU instruction completes on alu_done_i, a store after vl handshakes
 on the store port. vl must be between 1 and the register length.
 Done is a one-cycle pulse, and ready returns the cycle after it.
*/

`timescale 1ns/1ps

module lane_sequencer import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Instruction port
  input  logic     pe_req_valid_i,
  input  lane_op_e pe_op_i,
  input  vreg_t    pe_vd_i,
  input  vreg_t    pe_vs1_i,
  input  vreg_t    pe_vs2_i,
  input  vlen_t    pe_vl_i,
  output logic     pe_req_ready_o,
  output logic     pe_vinsn_done_o,
  // Operand requester
  output logic     opreq_valid_o,
  input  logic     opreq_ready_i,
  output vreg_t    opreq_vs1_o,
  output vreg_t    opreq_vs2_o,
  output vlen_t    opreq_vl_o,
  output logic     opreq_to_store_o,
  // ALU
  output logic     alu_cmd_valid_o,
  output lane_op_e alu_op_o,
  output vreg_t    alu_vd_o,
  output vlen_t    alu_vl_o,
  input  logic     alu_done_i,
  // Store port activity
  input  logic     stu_handshake_i
);

  seq_state_e state_q;
  logic       done_q;
  vlen_t      st_cnt_q;
  lane_op_e   op_q;
  vreg_t      vd_q;
  vreg_t      vs1_q;
  vreg_t      vs2_q;
  vlen_t      vl_q;
  logic       is_store;
  logic       finish;

  assign is_store = (op_q == OP_STORE);

  // Last store handshake, or the ALU reporting its final writeback
  assign finish = is_store ? (stu_handshake_i && (st_cnt_q + vlen_t'(1) == vl_q)) : alu_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      done_q   <= 1'b0;
      st_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (pe_req_valid_i) begin
            state_q  <= ISSUE;
            st_cnt_q <= '0;
          end
        end
        ISSUE: begin
          if (opreq_ready_i) begin
            state_q <= WAIT_DONE;
          end
        end
        WAIT_DONE: begin
          if (done_q) begin
            state_q <= IDLE;
          end else if (finish) begin
            done_q <= 1'b1;
          end
          if (stu_handshake_i) begin
            st_cnt_q <= st_cnt_q + vlen_t'(1);
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction fields, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i && pe_req_ready_o) begin
      op_q  <= pe_op_i;
      vd_q  <= pe_vd_i;
      vs1_q <= pe_vs1_i;
      vs2_q <= pe_vs2_i;
      vl_q  <= pe_vl_i;
    end
  end

  assign pe_req_ready_o  = (state_q == IDLE);
  assign pe_vinsn_done_o = done_q;

  assign opreq_valid_o    = (state_q == ISSUE);
  assign opreq_vs1_o      = vs1_q;
  assign opreq_vs2_o      = vs2_q;
  assign opreq_vl_o       = vl_q;
  assign opreq_to_store_o = is_store;

  // ALU command goes out together with the accepted operand command
  assign alu_cmd_valid_o = (state_q == ISSUE) && opreq_ready_i && !is_store;
  assign alu_op_o        = op_q;
  assign alu_vd_o        = vd_q;
  assign alu_vl_o        = vl_q;

  // Store handshakes and ALU completion only belong to the running instruction
  a_completion_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stu_handshake_i || alu_done_i) |-> (state_q == WAIT_DONE) && (is_store == stu_handshake_i));

endmodule

// ==== design/lane_settings.svh ====
/*
 Sizes of the reduced vector lane.
 LANE_ELEM_W must be a multiple of 8, one byte enable per byte.
 LANE_NR_VREGS and LANE_ELEMS_PER_VREG must be powers of two,
 since the VRF address is the register index next to the element index.
 Operand queues need a depth of at least 2.
*/

`ifndef LANE_SETTINGS_SVH
`define LANE_SETTINGS_SVH

// Datapath width of one element
`define LANE_ELEM_W 32

// VRF geometry of the lane
`define LANE_NR_VREGS 8
`define LANE_ELEMS_PER_VREG 8

// Default operand queue depth
`define LANE_OPQUEUE_DEPTH 4

`endif

// ==== design/operand_queue.sv ====
/*
 Operand FIFO between the VRF and a consumer.
 almost_free_o means two free slots, room for a read still in flight.
 Pushed data is visible at the output one cycle later. DEPTH >= 2.
*/

`timescale 1ns/1ps

`include "lane_settings.svh"

module operand_queue import lane_pkg::*; #(
  parameter int unsigned DEPTH = `LANE_OPQUEUE_DEPTH
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elem_t data_i,
  output logic  almost_free_o,
  output elem_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  elem_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              pop;

  assign pop           = valid_o && ready_i;
  assign valid_o       = (cnt_q != '0);
  assign data_o        = mem[rd_ptr_q];
  assign almost_free_o = (cnt_q <= CNT_W'(DEPTH - 2));

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop);
    end
  end

  // The requester must never push into a full queue
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (cnt_q != CNT_W'(DEPTH)));

endmodule

// ==== design/operand_requester.sv ====
/*
 VRF port arbiter and operand fetch.
 Fixed priority per cycle: ALU writeback, load write, one operand read.
 ALU operands are read as vs1 then vs2 for each element, a store reads
 only vs2. A read starts only when its queue has two free slots.
*/

`timescale 1ns/1ps

`include "lane_settings.svh"

module operand_requester import lane_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Operand command
  input  logic       opreq_valid_i,
  output logic       opreq_ready_o,
  input  vreg_t      opreq_vs1_i,
  input  vreg_t      opreq_vs2_i,
  input  vlen_t      opreq_vl_i,
  input  logic       opreq_to_store_i,
  // Load port
  input  logic       ldu_req_i,
  input  vaddr_t     ldu_addr_i,
  input  elem_t      ldu_wdata_i,
  input  strb_t      ldu_be_i,
  output logic       ldu_gnt_o,
  // ALU writeback
  input  logic       alu_wb_req_i,
  input  vaddr_t     alu_wb_addr_i,
  input  elem_t      alu_wb_data_i,
  output logic       alu_wb_gnt_o,
  // VRF
  output logic       vrf_req_o,
  output logic       vrf_we_o,
  output vaddr_t     vrf_addr_o,
  output elem_t      vrf_wdata_o,
  output strb_t      vrf_be_o,
  input  elem_t      vrf_rdata_i,
  // Operand queues, bit 0 vs1, bit 1 vs2, bit 2 store
  input  logic [2:0] q_almost_free_i,
  output logic [2:0] q_push_o,
  output elem_t      q_data_o
);

  logic       busy_q;
  logic       to_store_q;
  logic       phase_q;
  vreg_t      vs1_q;
  vreg_t      vs2_q;
  vlen_t      vl_q;
  vlen_t      cnt_q;
  logic       rd_valid_q;
  logic [1:0] rd_tgt_q;
  logic [1:0] rd_tgt;
  vreg_t      rd_reg;
  logic       rd_issue;
  logic       elem_step;

  // The vs2 phase also serves stores
  assign elem_step = to_store_q || phase_q;
  assign rd_tgt    = to_store_q ? 2'd2 : {1'b0, phase_q};
  assign rd_reg    = elem_step ? vs2_q : vs1_q;
  assign rd_issue  = busy_q && !alu_wb_req_i && !ldu_req_i && q_almost_free_i[rd_tgt];

  assign opreq_ready_o = !busy_q;
  assign alu_wb_gnt_o  = alu_wb_req_i;
  assign ldu_gnt_o     = ldu_req_i && !alu_wb_req_i;

  always_comb begin
    vrf_req_o = alu_wb_req_i || ldu_req_i || rd_issue;
    vrf_we_o  = alu_wb_req_i || ldu_req_i;
    if (alu_wb_req_i) begin
      vrf_addr_o  = alu_wb_addr_i;
      vrf_wdata_o = alu_wb_data_i;
      vrf_be_o    = '1;
    end else if (ldu_req_i) begin
      vrf_addr_o  = ldu_addr_i;
      vrf_wdata_o = ldu_wdata_i;
      vrf_be_o    = ldu_be_i;
    end else begin
      vrf_addr_o  = {rd_reg, velem_t'(cnt_q)};
      vrf_wdata_o = '0;
      vrf_be_o    = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      phase_q    <= 1'b0;
      cnt_q      <= '0;
      rd_valid_q <= 1'b0;
      rd_tgt_q   <= '0;
    end else begin
      rd_valid_q <= rd_issue;
      rd_tgt_q   <= rd_tgt;
      if (opreq_valid_i && !busy_q) begin
        busy_q  <= 1'b1;
        phase_q <= 1'b0;
        cnt_q   <= '0;
      end else if (rd_issue) begin
        phase_q <= !elem_step;
        if (elem_step) begin
          cnt_q <= cnt_q + vlen_t'(1);
          if (cnt_q + vlen_t'(1) == vl_q) begin
            busy_q <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (opreq_valid_i && opreq_ready_o) begin
      vs1_q      <= opreq_vs1_i;
      vs2_q      <= opreq_vs2_i;
      vl_q       <= opreq_vl_i;
      to_store_q <= opreq_to_store_i;
    end
  end

  // Read data returns one cycle later, steered to the queue it was read for
  assign q_push_o = rd_valid_q ? (3'b001 << rd_tgt_q) : 3'b000;
  assign q_data_o = vrf_rdata_i;

  // Each operand command covers 1 up to the register length of elements
  a_vl_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    opreq_valid_i && opreq_ready_o |-> (opreq_vl_i != '0) &&
    (opreq_vl_i <= vlen_t'(`LANE_ELEMS_PER_VREG)));

endmodule

// ==== design/vector_regfile.sv ====
/*
 Single-port VRF of one lane, one access per cycle.
 Writes honour the byte enables. Read data appears one cycle after
 the request and holds until the next read.
 Memory contents are undefined after reset.
*/

`timescale 1ns/1ps

module vector_regfile import lane_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  logic   we_i,
  input  vaddr_t addr_i,
  input  elem_t  wdata_i,
  input  strb_t  be_i,
  output elem_t  rdata_o
);

  elem_t mem [2**$bits(vaddr_t)];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// ==== files.f ====
+incdir+design
design/lane_pkg.sv
design/lane_sequencer.sv
design/operand_requester.sv
design/vector_regfile.sv
design/operand_queue.sv
design/lane_alu.sv
design/lane.sv
bench/tb_lane.sv

// ==== run.sh ====
#!/bin/sh
# Build the lane testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_lane -f files.f -o tb_lane \
  && ./obj_dir/tb_lane > sim.log 2>&1
grep -q '^TEST OK$' sim.log && echo "Simulation passed" \
  || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
